/* build.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_lru.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_responder.sv
tb/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator and run the dcache testbench

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module dcache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vdcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
exit 1

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic                        op,
    input  addr_t                       addr,
    input  wstrb_t                      wstrb,
    input  word_t                       wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output word_t                       rdata,
    output logic                        rd_req,
    output addr_t                       rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  line_t                       ret_data,
    output logic                        wr_req,
    output addr_t                       wr_addr,
    output line_t                       wr_data,
    input  logic                        wr_rdy,
    output logic                        rd_en,
    output index_t                      rd_index,
    input  tag_t [`DCACHE_WAYS-1:0]     way_tag,
    input  logic [`DCACHE_WAYS-1:0]     way_valid,
    input  logic [`DCACHE_WAYS-1:0]     way_dirty,
    input  line_t [`DCACHE_WAYS-1:0]    way_line,
    output logic                        fill_en,
    output way_t                        fill_way,
    output index_t                      fill_index,
    output tag_t                        fill_tag,
    output logic                        fill_dirty,
    output logic                        mark_en,
    output way_t                        mark_way,
    output index_t                      mark_index,
    output logic                        wr_en,
    output way_t                        wr_way,
    output index_t                      wr_index,
    output line_t                       wr_line,
    output line_strb_t                  wr_byte_en,
    output logic                        touch_en,
    output index_t                      touch_index,
    output way_t                        touch_way,
    output index_t                      query_index,
    input  way_t                        victim_way
);

    localparam int BANK_LSB = $clog2(`DCACHE_WORD_W / 8);

    cache_state_t state, next_state;
    logic         req_fire;
    logic         rb_op;
    tag_t         rb_tag;
    index_t       rb_index;
    offset_t      rb_offset;
    wstrb_t       rb_wstrb;
    word_t        rb_wdata;
    way_t         vb_way;
    tag_t         vb_tag;
    line_t        vb_line;
    logic [`DCACHE_WAYS-1:0] way_hit;
    logic         hit;
    way_t         hit_way;
    logic         lookup_hit;
    logic         victim_dirty;
    logic [`DCACHE_OFFSET_W-BANK_LSB-1:0] bank_sel;
    line_strb_t   store_strb;
    line_t        store_line;
    line_t        refill_line;

    assign req_fire = valid && addr_ok;
    assign addr_ok  = valid && (state == IDLE || (state == LOOKUP && hit && !rb_op));

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rb_op     <= op;
            rb_tag    <= addr[31 -: `DCACHE_TAG_W];
            rb_index  <= addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
            rb_offset <= addr[`DCACHE_OFFSET_W-1:0];
            rb_wstrb  <= wstrb;
            rb_wdata  <= wdata;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = way_valid[w] && (way_tag[w] == rb_tag);
            if (way_hit[w]) hit_way = way_t'(w);
        end
    end
    assign hit          = |way_hit;
    assign lookup_hit   = (state == LOOKUP) && hit;
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    // Victim snapshot, taken before the refill overwrites the set
    always_ff @(posedge clk) begin
        if (state == LOOKUP && !hit) begin
            vb_way  <= victim_way;
            vb_tag  <= way_tag[victim_way];
            vb_line <= way_line[victim_way];
        end
    end

    assign bank_sel   = rb_offset[`DCACHE_OFFSET_W-1:BANK_LSB];
    assign store_strb = line_strb_t'(rb_wstrb) << (bank_sel * (`DCACHE_WORD_W / 8));
    assign store_line = {`DCACHE_BANKS{rb_wdata}};

    // Store bytes win over the returned line
    always_comb begin
        for (int b = 0; b < $bits(line_strb_t); b++) begin
            refill_line[8*b +: 8] = (rb_op && store_strb[b]) ? store_line[8*b +: 8]
                                                             : ret_data[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (req_fire) next_state = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    next_state = req_fire ? LOOKUP : IDLE;
                end else begin
                    next_state = victim_dirty ? MISS : REPLACE;
                end
            end
            MISS:    if (wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    assign data_ok = lookup_hit || (state == REFILL && ret_valid);
    assign rdata   = (state == REFILL) ? ret_data[bank_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W]
                                       : way_line[hit_way][bank_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];

    assign wr_req  = (state == MISS);
    assign wr_addr = {vb_tag, rb_index, {`DCACHE_OFFSET_W{1'b0}}};
    assign wr_data = vb_line;
    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rb_tag, rb_index, {`DCACHE_OFFSET_W{1'b0}}};

    assign rd_en       = req_fire;
    assign rd_index    = addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign fill_en     = (state == REFILL) && ret_valid;
    assign fill_way    = vb_way;
    assign fill_index  = rb_index;
    assign fill_tag    = rb_tag;
    assign fill_dirty  = rb_op;
    assign mark_en     = lookup_hit && rb_op;
    assign mark_way    = hit_way;
    assign mark_index  = rb_index;
    assign wr_en       = mark_en || fill_en;
    assign wr_way      = fill_en ? vb_way : hit_way;
    assign wr_index    = rb_index;
    assign wr_line     = fill_en ? refill_line : store_line;
    assign wr_byte_en  = fill_en ? '1 : store_strb;
    assign touch_en    = lookup_hit || fill_en;
    assign touch_index = rb_index;
    assign touch_way   = fill_en ? vb_way : hit_way;
    assign query_index = rb_index;

    // A hit matches one way only
    assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> state == REFILL || $onehot(way_hit));

    // Line returns only while a refill waits
    assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == REFILL);

endmodule

/* src/dcache_data_array.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_data_array import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        rd_en,
    input  index_t                      rd_index,
    output line_t [`DCACHE_WAYS-1:0]    way_line,
    input  logic                        wr_en,
    input  way_t                        wr_way,
    input  index_t                      wr_index,
    input  line_t                       wr_line,
    input  line_strb_t                  wr_byte_en
);

    localparam int LINE_BYTES = $bits(line_strb_t);

    line_t line_mem [`DCACHE_WAYS][`DCACHE_SETS];

    // Byte-granular write, shared by refill and store hit
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_byte_en[b]) begin
                    line_mem[wr_way][wr_index][8*b +: 8] <= wr_line[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                way_line[w] <= line_mem[w][rd_index];
            end
        end
    end

endmodule

/* src/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Address split
`define DCACHE_TAG_W    20
`define DCACHE_INDEX_W  8
`define DCACHE_OFFSET_W 4

// Line geometry
`define DCACHE_WORD_W   32
`define DCACHE_BANKS    4

`define DCACHE_SETS     256
`define DCACHE_WAYS     2

`endif

/* src/dcache_lru.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_lru import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        touch_en,
    input  index_t                      touch_index,
    input  way_t                        touch_way,
    input  index_t                      query_index,
    input  logic [`DCACHE_WAYS-1:0]     way_valid,
    output way_t                        victim_way
);

    way_t last_hit [`DCACHE_SETS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                last_hit[s] <= '0;
            end
        end else if (touch_en) begin
            last_hit[touch_index] <= touch_way;
        end
    end

    // Lowest invalid way wins, else the one not hit last
    always_comb begin
        victim_way = ~last_hit[query_index];
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) victim_way = way_t'(w);
        end
    end

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

`include "dcache_defines.svh"

    typedef logic [31:0]                                addr_t;
    typedef logic [`DCACHE_TAG_W-1:0]                   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]                 index_t;
    typedef logic [`DCACHE_OFFSET_W-1:0]                offset_t;
    typedef logic [`DCACHE_WORD_W-1:0]                  word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0]                wstrb_t;
    // Bank 0 sits in the low word
    typedef logic [`DCACHE_BANKS*`DCACHE_WORD_W-1:0]    line_t;
    typedef logic [`DCACHE_BANKS*`DCACHE_WORD_W/8-1:0]  line_strb_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0]            way_t;

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REPLACE, REFILL} cache_state_t;

endpackage

/* src/dcache_tag_array.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tag_array import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        rd_en,
    input  index_t                      rd_index,
    output tag_t [`DCACHE_WAYS-1:0]     way_tag,
    output logic [`DCACHE_WAYS-1:0]     way_valid,
    output logic [`DCACHE_WAYS-1:0]     way_dirty,
    input  logic                        fill_en,
    input  way_t                        fill_way,
    input  index_t                      fill_index,
    input  tag_t                        fill_tag,
    input  logic                        fill_dirty,
    input  logic                        mark_en,
    input  way_t                        mark_way,
    input  index_t                      mark_index
);

    tag_t                    tag_mem    [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] valid_bits [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0] dirty_bits [`DCACHE_WAYS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][fill_index] <= fill_tag;
        end
        if (rd_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                way_tag[w] <= tag_mem[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else if (fill_en) begin
            valid_bits[fill_way][fill_index] <= 1'b1;
            dirty_bits[fill_way][fill_index] <= fill_dirty;
        end else if (mark_en) begin
            dirty_bits[mark_way][mark_index] <= 1'b1;
        end
    end

    // Status read out next to the tag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            way_valid <= '0;
            way_dirty <= '0;
        end else if (rd_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                way_valid[w] <= valid_bits[w][rd_index];
                way_dirty[w] <= dirty_bits[w][rd_index];
            end
        end
    end

    // Refill and store hit never land in the same cycle
    assert property (@(posedge clk) disable iff (!resetn) !(fill_en && mark_en));

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    valid,
    input  logic    op,
    input  addr_t   addr,
    input  wstrb_t  wstrb,
    input  word_t   wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    output logic    rd_req,
    output addr_t   rd_addr,
    input  logic    rd_rdy,
    input  logic    ret_valid,
    input  line_t   ret_data,
    output logic    wr_req,
    output addr_t   wr_addr,
    output line_t   wr_data,
    input  logic    wr_rdy
);

    // Shared read port of both arrays
    logic                        rd_en;
    index_t                      rd_index;
    tag_t [`DCACHE_WAYS-1:0]     way_tag;
    logic [`DCACHE_WAYS-1:0]     way_valid;
    logic [`DCACHE_WAYS-1:0]     way_dirty;
    line_t [`DCACHE_WAYS-1:0]    way_line;
    logic                        fill_en, fill_dirty, mark_en;
    way_t                        fill_way, mark_way;
    index_t                      fill_index, mark_index;
    tag_t                        fill_tag;
    // Data array write port
    logic                        wr_en;
    way_t                        wr_way;
    index_t                      wr_index;
    line_t                       wr_line;
    line_strb_t                  wr_byte_en;
    logic                        touch_en;
    index_t                      touch_index, query_index;
    way_t                        touch_way, victim_way;

    dcache_ctrl       u_ctrl (.*);
    dcache_tag_array  u_tag  (.*);
    dcache_data_array u_data (.*);
    dcache_lru        u_lru  (.*);

endmodule

/* tb/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int SEED        = 37;
    localparam int OPS         = 3000;
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = OPS * 40 * CLK_NS;

    // Four tags over four sets, so two ways keep getting evicted
    localparam tag_t   TAG_POOL   [4] = '{20'h00012, 20'h0a5c3, 20'h7ff01, 20'h00400};
    localparam index_t INDEX_POOL [4] = '{8'h00, 8'h3c, 8'h81, 8'hff};

    typedef struct packed {
        logic  is_load;
        logic  must_miss;
        logic  after_store;
        int    rd_mark;
        word_t word;
    } pending_t;

    logic   clk;
    logic   resetn;
    logic   valid;
    logic   op;
    addr_t  addr;
    wstrb_t wstrb;
    word_t  wdata;
    logic   addr_ok;
    logic   data_ok;
    word_t  rdata;
    logic   rd_req;
    addr_t  rd_addr;
    logic   rd_rdy;
    logic   ret_valid;
    line_t  ret_data;
    logic   wr_req;
    addr_t  wr_addr;
    line_t  wr_data;
    logic   wr_rdy;

    word_t    model     [addr_t];
    bit       seen_line [addr_t];
    pending_t pend_q    [$];
    int       errors;
    int       issued;
    int       answered;
    int       rd_count;
    int       follow_hit;
    int       follow_miss;
    logic     prev_store;
    logic     last_store_missed;
    addr_t    last_addr;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    dcache_top DUT (.*);

    tb_mem_responder u_mem (.*);

    function automatic word_t init_word(addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]};
    endfunction

    function automatic addr_t word_base(addr_t a);
        return {a[31:2], 2'b00};
    endfunction

    function automatic addr_t line_base(addr_t a);
        return {a[31:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic word_t model_word(addr_t a);
        if (model.exists(word_base(a))) begin
            return model[word_base(a)];
        end
        return init_word(a);
    endfunction

    // Bank 0 in the low word
    function automatic line_t model_line(addr_t la);
        line_t l;
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            l[`DCACHE_WORD_W*b +: `DCACHE_WORD_W] = model_word(la + addr_t'(4 * b));
        end
        return l;
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, wstrb_t strb);
        word_t m;
        m = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) m[8*i +: 8] = new_w[8*i +: 8];
        end
        return m;
    endfunction

    task automatic flag_mismatch(string what, line_t got, line_t expected);
        errors++;
        $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
                 $time, what, got, expected);
    endtask

    task automatic drive_next();
        int unsigned r;
        r = $urandom_range(99, 0);
        valid <= 1'b1;
        wstrb <= 4'($urandom_range(15, 1));
        wdata <= $urandom();
        if (prev_store && r < 30) begin
            // Read back the word just stored
            op   <= 1'b0;
            addr <= last_addr;
        end else begin
            op   <= (r >= 60) && (issued != 0);
            addr <= {TAG_POOL[2'($urandom_range(3, 0))], INDEX_POOL[2'($urandom_range(3, 0))],
                     2'($urandom_range(3, 0)), 2'b00};
        end
    endtask

    initial begin
        pending_t p;
        valid = 1'b0;
        op    = 1'b0;
        addr  = '0;
        wstrb = '0;
        wdata = '0;
        errors = 0;
        issued = 0;
        answered = 0;
        rd_count = 0;
        follow_hit = 0;
        follow_miss = 0;
        prev_store = 1'b0;
        last_store_missed = 1'b0;
        last_addr = '0;
        void'($urandom(SEED));

        wait (resetn === 1'b1);
        // Quiet bus while nothing is requested
        repeat (5) begin
            @(posedge clk);
            if (data_ok || rd_req || wr_req) begin
                errors++;
                $display("CHECK FAILED at %0d ns: DUT active after reset with valid low", $time);
            end
        end

        while (issued < OPS || pend_q.size() != 0) begin
            @(posedge clk);
            if (wr_req && wr_rdy) begin
                if (wr_addr != line_base(wr_addr)) begin
                    flag_mismatch("write-back address alignment", line_t'(wr_addr),
                                  line_t'(line_base(wr_addr)));
                end
                if (wr_data !== model_line(wr_addr)) begin
                    flag_mismatch("write-back line", wr_data, model_line(wr_addr));
                end
            end
            if (rd_req && rd_rdy) begin
                rd_count++;
                if (rd_addr != line_base(last_addr)) begin
                    flag_mismatch("refill address", line_t'(rd_addr),
                                  line_t'(line_base(last_addr)));
                end
            end
            if (data_ok) begin
                if (pend_q.size() == 0) begin
                    errors++;
                    $display("CHECK FAILED at %0d ns: data_ok with no request pending", $time);
                end else begin
                    p = pend_q.pop_front();
                    answered++;
                    if (p.must_miss && p.rd_mark == rd_count) begin
                        errors++;
                        $display("CHECK FAILED at %0d ns: first access to a line without rd_req",
                                 $time);
                    end
                    if (p.is_load && rdata !== p.word) begin
                        flag_mismatch("load data", line_t'(rdata), line_t'(p.word));
                    end
                    if (!p.is_load) last_store_missed = (rd_count != p.rd_mark);
                    if (p.after_store && last_store_missed) follow_miss++;
                    else if (p.after_store) follow_hit++;
                end
            end

            if (valid && addr_ok) begin
                p.is_load     = !op;
                p.must_miss   = !seen_line.exists(line_base(addr));
                p.after_store = !op && prev_store && (word_base(addr) == word_base(last_addr));
                p.rd_mark     = rd_count;
                if (op) model[word_base(addr)] = merge_bytes(model_word(addr), wdata, wstrb);
                p.word = model_word(addr);
                pend_q.push_back(p);
                seen_line[line_base(addr)] = 1'b1;
                prev_store = op;
                last_addr  = addr;
                issued++;
                if (issued < OPS && $urandom_range(9, 0) != 0) drive_next();
                else valid <= 1'b0;
            end else if (!valid && issued < OPS) begin
                drive_next();
            end
        end

        repeat (4) begin
            @(posedge clk);
            if (data_ok) begin
                errors++;
                $display("CHECK FAILED at %0d ns: data_ok after the last response", $time);
            end
        end

        if (answered != issued) begin
            flag_mismatch("data_ok count", line_t'(answered), line_t'(issued));
        end
        if (follow_hit == 0 || follow_miss == 0) begin
            errors++;
            $display("Load after store was not seen on both paths: %0d after hit, %0d after miss",
                     follow_hit, follow_miss);
        end
        $display("Requests %0d, data_ok %0d, errors %0d", issued, answered, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before all requests were answered",
                 WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released right after an edge so the DUT sees it cleanly
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

/* tb/tb_mem_responder.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_mem_responder import dcache_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  rd_rdy = 1'b0,
    output logic  ret_valid = 1'b0,
    output line_t ret_data = '0,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  line_t wr_data,
    output logic  wr_rdy = 1'b0
);

    line_t       mem [addr_t];
    addr_t       ret_addr;
    int unsigned rd_wait;
    int unsigned wr_wait;
    int unsigned ret_wait;

    // Power-up contents, a mix of every address bit
    function automatic word_t init_word(addr_t a);
        addr_t w;
        w = {a[31:2], 2'b00};
        return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]};
    endfunction

    function automatic line_t read_line(addr_t la);
        line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int b = 0; b < `DCACHE_BANKS; b++) begin
            l[`DCACHE_WORD_W*b +: `DCACHE_WORD_W] = init_word(la + addr_t'(4 * b));
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_wait  <= 0;
            rd_wait   <= $urandom_range(3, 0);
            wr_wait   <= $urandom_range(3, 0);
        end else begin
            wr_rdy <= 1'b0;
            if (wr_req && wr_rdy) begin
                mem[wr_addr] = wr_data;
                wr_wait <= $urandom_range(3, 0);
            end else if (wr_req) begin
                if (wr_wait == 0) wr_rdy <= 1'b1;
                else wr_wait <= wr_wait - 1;
            end

            rd_rdy <= 1'b0;
            if (rd_req && rd_rdy) begin
                ret_addr <= rd_addr;
                ret_wait <= $urandom_range(4, 1);
                rd_wait  <= $urandom_range(3, 0);
            end else if (rd_req) begin
                if (rd_wait == 0) rd_rdy <= 1'b1;
                else rd_wait <= rd_wait - 1;
            end

            // One-cycle return of the whole line
            ret_valid <= 1'b0;
            if (ret_wait == 1) begin
                ret_valid <= 1'b1;
                ret_data  <= read_line(ret_addr);
            end
            if (ret_wait != 0) ret_wait <= ret_wait - 1;
        end
    end

endmodule
